// ==== rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Instruction memory depth in 32-bit words
`define RV_IMEM_WORDS 64

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 64

// Byte address of the LED register. A word store here bypasses the data memory
`define RV_LED_ADDR 32'h100

`endif

// ==== rv_pkg.sv ====
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_num_t;
	typedef logic [6:0]  opcode_t;

	// Major opcodes of the supported subset
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL    = 7'b1101111;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B	// LUI passes the U immediate
	} alu_op_e;

	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t inst;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		word_t    op_a;
		word_t    op_b;
		word_t    store_data;
		reg_num_t rd;
		logic     we;
		alu_op_e  alu_op;
		logic     load;
		logic     store;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		word_t    result;
		word_t    store_data;
		reg_num_t rd;
		logic     we;
		logic     load;
		logic     store;
	} ex_mem_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		word_t    data;
		reg_num_t rd;
		logic     we;
	} mem_wb_t;

endpackage

// ==== rv_fetch.sv ====
`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_fetch import rv_pkg::*; (
	input  logic   i_clk,
	input  logic   i_rst_n,
	input  logic   i_load_en,
	input  logic   i_load_we,
	input  word_t  i_load_addr,
	input  word_t  i_load_data,
	input  logic   i_redirect,
	input  word_t  i_redirect_pc,
	output if_id_t o_if_id
);

	localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);

	word_t pc;
	word_t pc_next;
	word_t imem [`RV_IMEM_WORDS];

	// Program image, written only while the core is held
	always_ff @(posedge i_clk) begin
		if (i_load_en && i_load_we) begin
			imem[i_load_addr[IMEM_AW-1:0]] <= i_load_data;
		end
	end

	assign pc_next = i_redirect ? i_redirect_pc : pc + 32'd4;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n || i_load_en) begin
			pc <= '0;	// Load mode parks fetch at the reset vector
		end else begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge i_clk) begin
		o_if_id.pc   <= pc;
		o_if_id.inst <= imem[pc[IMEM_AW+1:2]];
		if (!i_rst_n) begin
			o_if_id.valid <= 1'b0;
		end else begin
			o_if_id.valid <= !i_load_en && !i_redirect;	// Squash slot behind a taken branch
		end
	end

	// Decode only redirects from a valid entry
	a_redirect_from_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_redirect |-> o_if_id.valid);

endmodule

// ==== rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  logic    i_load_en,
	input  if_id_t  i_if_id,
	input  mem_wb_t i_mem_wb,
	output logic    o_redirect,
	output word_t   o_redirect_pc,
	output id_ex_t  o_id_ex
);

	word_t    regs [32];
	word_t    inst;
	opcode_t  opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_num_t rs1;
	reg_num_t rs2;
	word_t    rs1_val;
	word_t    rs2_val;
	word_t    imm_i;
	word_t    imm_s;
	word_t    imm_b;
	word_t    imm_u;
	word_t    imm_j;
	logic     wb_en;
	logic     taken;
	id_ex_t   id_ex_d;

	assign inst   = i_if_id.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign wb_en = i_mem_wb.valid && i_mem_wb.we && (i_mem_wb.rd != '0);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[i_mem_wb.rd] <= i_mem_wb.data;
		end
	end

	// Write-through lets decode see a result in the cycle it retires
	function automatic word_t read_reg(input reg_num_t num);
		word_t val;
		if (num == '0) begin
			val = '0;
		end else if (wb_en && (i_mem_wb.rd == num)) begin
			val = i_mem_wb.data;
		end else begin
			val = regs[num];
		end
		return val;
	endfunction

	always_comb begin
		rs1_val = read_reg(rs1);
		rs2_val = read_reg(rs2);
	end

	always_comb begin
		id_ex_d.valid      = i_if_id.valid;
		id_ex_d.pc         = i_if_id.pc;
		id_ex_d.op_a       = rs1_val;
		id_ex_d.op_b       = rs2_val;
		id_ex_d.store_data = rs2_val;
		id_ex_d.rd         = inst[11:7];
		id_ex_d.we         = 1'b0;	// Unsupported opcodes retire without a write
		id_ex_d.alu_op     = ALU_ADD;
		id_ex_d.load       = 1'b0;
		id_ex_d.store      = 1'b0;
		taken              = 1'b0;
		o_redirect_pc      = i_if_id.pc + imm_b;
		case (opcode)
			OPC_OP: begin
				id_ex_d.we = 1'b1;
				case (funct3)
					3'b000: id_ex_d.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
					3'b111: id_ex_d.alu_op = ALU_AND;
					3'b110: id_ex_d.alu_op = ALU_OR;
					3'b100: id_ex_d.alu_op = ALU_XOR;
					3'b010: id_ex_d.alu_op = ALU_SLT;
					default: id_ex_d.we = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				id_ex_d.op_b = imm_i;
				id_ex_d.we   = (funct3 == 3'b000);	// ADDI only
			end
			OPC_LUI: begin
				id_ex_d.op_b   = imm_u;
				id_ex_d.alu_op = ALU_PASS_B;
				id_ex_d.we     = 1'b1;
			end
			OPC_LOAD: begin
				id_ex_d.op_b = imm_i;
				id_ex_d.load = (funct3 == 3'b010);
				id_ex_d.we   = (funct3 == 3'b010);
			end
			OPC_STORE: begin
				id_ex_d.op_b  = imm_s;
				id_ex_d.store = (funct3 == 3'b010);
			end
			OPC_BRANCH: begin
				case (funct3)
					3'b000: taken = (rs1_val == rs2_val);	// BEQ
					3'b001: taken = (rs1_val != rs2_val);	// BNE
					default: taken = 1'b0;
				endcase
			end
			OPC_JAL: begin
				id_ex_d.op_a  = i_if_id.pc;	// Link value pc+4 comes out of the ALU
				id_ex_d.op_b  = 32'd4;
				id_ex_d.we    = 1'b1;
				taken         = 1'b1;
				o_redirect_pc = i_if_id.pc + imm_j;
			end
			default: ;
		endcase
		if (id_ex_d.rd == '0) begin
			id_ex_d.we = 1'b0;
		end
	end

	assign o_redirect = i_if_id.valid && taken;

	always_ff @(posedge i_clk) begin
		o_id_ex <= id_ex_d;
		if (!i_rst_n || i_load_en) begin
			o_id_ex.valid <= 1'b0;
		end
	end

	// Writeback from the memory stage never lands in x0
	a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_mem_wb.valid && i_mem_wb.we |-> i_mem_wb.rd != '0);

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  logic    i_load_en,
	input  id_ex_t  i_id_ex,
	output ex_mem_t o_ex_mem
);

	word_t   alu_a;
	word_t   alu_b;
	word_t   alu_result;
	ex_mem_t ex_mem_d;

	assign alu_a = i_id_ex.op_a;
	assign alu_b = i_id_ex.op_b;

	always_comb begin
		case (i_id_ex.alu_op)
			ALU_ADD:    alu_result = alu_a + alu_b;
			ALU_SUB:    alu_result = alu_a - alu_b;
			ALU_AND:    alu_result = alu_a & alu_b;
			ALU_OR:     alu_result = alu_a | alu_b;
			ALU_XOR:    alu_result = alu_a ^ alu_b;
			ALU_SLT:    alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
			ALU_PASS_B: alu_result = alu_b;
			default:    alu_result = '0;
		endcase
	end

	// Address for loads and stores is the same add as ADDI
	always_comb begin
		ex_mem_d.valid      = i_id_ex.valid;
		ex_mem_d.pc         = i_id_ex.pc;
		ex_mem_d.result     = alu_result;
		ex_mem_d.store_data = i_id_ex.store_data;
		ex_mem_d.rd         = i_id_ex.rd;
		ex_mem_d.we         = i_id_ex.we;
		ex_mem_d.load       = i_id_ex.load;
		ex_mem_d.store      = i_id_ex.store;
	end

	always_ff @(posedge i_clk) begin
		o_ex_mem <= ex_mem_d;
		if (!i_rst_n || i_load_en) begin
			o_ex_mem.valid <= 1'b0;
		end
	end

endmodule

// ==== rv_memory.sv ====
`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_memory import rv_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_load_en,
	input  ex_mem_t    i_ex_mem,
	output mem_wb_t    o_mem_wb,
	output logic [3:0] o_leds
);

	localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

	word_t              dmem [`RV_DMEM_WORDS];
	logic [DMEM_AW-1:0] dmem_idx;
	logic               active;
	logic               led_hit;
	logic               dmem_we;
	logic               led_we;
	word_t              load_data;
	mem_wb_t            mem_wb_d;

	assign active   = i_ex_mem.valid && !i_load_en;
	assign dmem_idx = i_ex_mem.result[DMEM_AW+1:2];	// Word addressed
	assign led_hit  = (i_ex_mem.result == `RV_LED_ADDR);
	assign dmem_we  = active && i_ex_mem.store && !led_hit;
	assign led_we   = active && i_ex_mem.store && led_hit;

	// Cleared on reset so untouched words read zero
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (dmem_we) begin
			dmem[dmem_idx] <= i_ex_mem.store_data;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_leds <= '0;
		end else if (led_we) begin
			o_leds <= i_ex_mem.store_data[3:0];
		end
	end

	assign load_data = dmem[dmem_idx];

	always_comb begin
		mem_wb_d.valid = i_ex_mem.valid;
		mem_wb_d.pc    = i_ex_mem.pc;
		mem_wb_d.data  = i_ex_mem.load ? load_data : i_ex_mem.result;
		mem_wb_d.rd    = i_ex_mem.rd;
		mem_wb_d.we    = i_ex_mem.we;
	end

	always_ff @(posedge i_clk) begin
		o_mem_wb <= mem_wb_d;
		if (!i_rst_n || i_load_en) begin
			o_mem_wb.valid <= 1'b0;
		end
	end

	// Decode sets at most one of the two access flags
	a_load_xor_store: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_ex_mem.valid |-> !(i_ex_mem.load && i_ex_mem.store));

endmodule

// ==== rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_load_en,
	input  logic       i_load_we,
	input  word_t      i_load_addr,
	input  word_t      i_load_data,
	output logic       o_retire,
	output word_t      o_retire_pc,
	output logic       o_retire_we,
	output reg_num_t   o_retire_rd,
	output word_t      o_retire_data,
	output logic [3:0] o_leds
);

	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;
	logic    redirect;
	word_t   redirect_pc;

	rv_fetch u_fetch (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_load_en     (i_load_en),
		.i_load_we     (i_load_we),
		.i_load_addr   (i_load_addr),
		.i_load_data   (i_load_data),
		.i_redirect    (redirect),
		.i_redirect_pc (redirect_pc),
		.o_if_id       (if_id)
	);

	rv_decode u_decode (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_load_en     (i_load_en),
		.i_if_id       (if_id),
		.i_mem_wb      (mem_wb),	// Writeback path into the register file
		.o_redirect    (redirect),
		.o_redirect_pc (redirect_pc),
		.o_id_ex       (id_ex)
	);

	rv_execute u_execute (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_load_en (i_load_en),
		.i_id_ex   (id_ex),
		.o_ex_mem  (ex_mem)
	);

	rv_memory u_memory (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_load_en (i_load_en),
		.i_ex_mem  (ex_mem),
		.o_mem_wb  (mem_wb),
		.o_leds    (o_leds)
	);

	assign o_retire      = mem_wb.valid;
	assign o_retire_pc   = mem_wb.pc;
	assign o_retire_we   = mem_wb.we;
	assign o_retire_rd   = mem_wb.rd;
	assign o_retire_data = mem_wb.data;

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS  = 20,
	parameter int RST_CYCLES = 4
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		#1 o_rst_n = 1'b1;	// Released just after an edge like all other inputs
	end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import rv_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_load_en,
	input  mem_wb_t    i_exp,
	input  logic [3:0] i_exp_leds,
	input  logic       i_retire,
	input  word_t      i_retire_pc,
	input  logic       i_retire_we,
	input  reg_num_t   i_retire_rd,
	input  word_t      i_retire_data,
	input  logic [3:0] i_leds,
	output int         o_pending,
	output int         o_errors,
	output int         o_checks
);

	typedef struct packed {
		mem_wb_t    ret;
		logic [3:0] leds;
	} exp_rec_t;

	exp_rec_t exp_q [$];
	exp_rec_t head;
	word_t    idle_pc;
	logic     load_en_q;

	task automatic check_field(input string name, input word_t got, input word_t want);
		if (got !== want) begin
			$display("Fail %s: got 0x%08h, expected 0x%08h", name, got, want);
			o_errors++;
		end
	endtask

	// Sampled on the falling edge, half a cycle away from every update
	always @(negedge i_clk) begin
		if (!i_rst_n) begin
			exp_q.delete();
			idle_pc   = '1;
			load_en_q = 1'b1;
			o_errors  = 0;
			o_checks  = 0;
		end else begin
			if (i_exp.valid) begin
				exp_q.push_back({i_exp, i_exp_leds});
			end
			if (i_retire && i_load_en && load_en_q) begin
				$display("Retire at pc 0x%08h while the core is held for loading", i_retire_pc);
				o_errors++;
			end else if (i_retire && exp_q.size() == 0) begin
				// Once a program has drained only its closing JAL keeps looping
				if (i_retire_pc != idle_pc || i_retire_we) begin
					$display("Retire at pc 0x%08h with no instruction expected", i_retire_pc);
					o_errors++;
				end
			end else if (i_retire) begin
				head = exp_q.pop_front();
				o_checks++;
				check_field("o_retire_pc", i_retire_pc, head.ret.pc);
				check_field("o_retire_we", word_t'(i_retire_we), word_t'(head.ret.we));
				if (head.ret.we) begin
					check_field("o_retire_rd", word_t'(i_retire_rd), word_t'(head.ret.rd));
					check_field("o_retire_data", i_retire_data, head.ret.data);
				end
				check_field("o_leds", word_t'(i_leds), word_t'(head.leds));	// LEDs move with the retire
				idle_pc = head.ret.pc;
			end
			load_en_q = i_load_en;
		end
		o_pending = exp_q.size();
	end

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

`include "rv_defines.svh"

module tb_rv_core import rv_pkg::*; ();

	localparam int    N_TESTS        = 6;
	localparam int    SLOTS          = `RV_IMEM_WORDS / 4;
	localparam int    IMEM_AW        = $clog2(`RV_IMEM_WORDS);
	localparam int    DMEM_AW        = $clog2(`RV_DMEM_WORDS);
	localparam int    TIMEOUT_CYCLES = N_TESTS * (8 * `RV_IMEM_WORDS + 100);
	localparam word_t NOP            = 32'h0000_0013;

	logic       clk;
	logic       rst_n;
	logic       load_en;
	logic       load_we;
	word_t      load_addr;
	word_t      load_data;
	logic       retire;
	word_t      retire_pc;
	logic       retire_we;
	reg_num_t   retire_rd;
	word_t      retire_data;
	logic [3:0] leds;
	mem_wb_t    exp_rec;
	logic [3:0] exp_leds;
	int         pending;
	int         errors;
	int         checks;
	int         cycles;
	int         tests_run;

	word_t      prog [`RV_IMEM_WORDS];
	word_t      model_regs [32];
	word_t      model_dmem [`RV_DMEM_WORDS];
	logic [3:0] model_leds;
	mem_wb_t    exp_q [$];
	logic [3:0] led_q [$];

	tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(4)) u_clk_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	rv_core_top UUT (
		.i_clk         (clk),
		.i_rst_n       (rst_n),
		.i_load_en     (load_en),
		.i_load_we     (load_we),
		.i_load_addr   (load_addr),
		.i_load_data   (load_data),
		.o_retire      (retire),
		.o_retire_pc   (retire_pc),
		.o_retire_we   (retire_we),
		.o_retire_rd   (retire_rd),
		.o_retire_data (retire_data),
		.o_leds        (leds)
	);

	tb_checker u_checker (
		.i_clk         (clk),
		.i_rst_n       (rst_n),
		.i_load_en     (load_en),
		.i_exp         (exp_rec),
		.i_exp_leds    (exp_leds),
		.i_retire      (retire),
		.i_retire_pc   (retire_pc),
		.i_retire_we   (retire_we),
		.i_retire_rd   (retire_rd),
		.i_retire_data (retire_data),
		.i_leds        (leds),
		.o_pending     (pending),
		.o_errors      (errors),
		.o_checks      (checks)
	);

	function automatic reg_num_t pick_reg();
		return reg_num_t'($urandom % 8);	// Few registers so branch operands often match
	endfunction

	function automatic int pick_one(input int a, input int b, input int c);
		int r;
		r = $urandom % 3;
		return (r == 0) ? a : (r == 1) ? b : c;
	endfunction

	function automatic logic [11:0] data_offset(input int words);
		return 12'(4 * ($urandom % words));
	endfunction

	function automatic word_t enc_r(input int sel, input reg_num_t rd, input reg_num_t rs1,
			input reg_num_t rs2);
		logic [2:0] f3;
		logic [6:0] f7;
		f7 = (sel == 1) ? 7'h20 : 7'h00;
		case (sel)
			2: f3 = 3'b111;
			3: f3 = 3'b110;
			4: f3 = 3'b100;
			5: f3 = 3'b010;
			default: f3 = 3'b000;	// ADD and SUB
		endcase
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input reg_num_t rs1,
			input logic [2:0] f3, input reg_num_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input reg_num_t rs2,
			input reg_num_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(input logic [12:0] imm, input reg_num_t rs2,
			input reg_num_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t enc_j(input logic [20:0] imm, input reg_num_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// Categories: 0 R-type, 1 ADDI, 2 LUI, 3 SW, 4 LW, 5 branch, 6 JAL, 7 LED store
	function automatic word_t gen_inst(input int mode, input int slot);
		int          cat;
		reg_num_t    rd;
		reg_num_t    rs1;
		reg_num_t    rs2;
		logic [12:0] boff;
		word_t       inst;
		rd   = pick_reg();
		rs1  = pick_reg();
		rs2  = ($urandom % 2 == 0) ? rs1 : pick_reg();
		boff = 13'((1 + $urandom % (SLOTS - 1 - slot)) * 16);	// Forward to a later slot
		case (mode)
			0: cat = pick_one(0, 1, 2);
			1: cat = pick_one(0, 1, 1);
			2: cat = pick_one(1, 3, 4);
			3: cat = pick_one(1, 5, 6);
			4: cat = pick_one(0, 1, 7);
			default: cat = $urandom % 8;
		endcase
		if (mode == 1 && $urandom % 2 == 0) begin
			rd = '0;
		end
		case (cat)
			0: inst = enc_r(int'($urandom % 6), rd, rs1, rs2);
			1: inst = enc_i(12'($urandom), rs1, 3'b000, rd, 7'b0010011);
			2: inst = {20'($urandom), rd, 7'b0110111};
			3: inst = enc_s(data_offset(8), rs2, '0);
			4: inst = enc_i(data_offset(12), '0, 3'b010, rd, 7'b0000011);	// Some words never stored
			5: inst = enc_b(boff, rs2, rs1, ($urandom % 2 == 0) ? 3'b000 : 3'b001);
			6: inst = enc_j(21'(boff), reg_num_t'(8 + $urandom % 8));	// Link never read by the target
			default: inst = enc_s(12'(`RV_LED_ADDR), rs2, '0);
		endcase
		return inst;
	endfunction

	function automatic void build_program(input int mode);
		for (int s = 0; s < SLOTS; s++) begin
			prog[4 * s] = (s == SLOTS - 1) ? enc_j(21'd0, '0) : gen_inst(mode, s);
			for (int k = 1; k < 4; k++) begin
				prog[4 * s + k] = NOP;
			end
		end
	endfunction

	// Runs the program on the model state and queues one record per retire
	function automatic void run_reference();
		word_t    pc;
		word_t    next_pc;
		word_t    inst;
		word_t    a;
		word_t    b;
		word_t    res;
		word_t    addr;
		reg_num_t rd;
		logic     we;
		logic     done;
		pc   = '0;
		done = 1'b0;
		while (!done) begin
			inst    = prog[pc[IMEM_AW+1:2]];
			rd      = inst[11:7];
			a       = model_regs[inst[19:15]];
			b       = model_regs[inst[24:20]];
			next_pc = pc + 32'd4;
			res     = '0;
			we      = 1'b0;
			case (inst[6:0])
				7'b0110011: begin
					we = 1'b1;
					case (inst[14:12])
						3'b000: res = inst[30] ? a - b : a + b;
						3'b111: res = a & b;
						3'b110: res = a | b;
						3'b100: res = a ^ b;
						default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					endcase
				end
				7'b0010011: begin
					res = a + {{20{inst[31]}}, inst[31:20]};
					we  = 1'b1;
				end
				7'b0110111: begin
					res = {inst[31:12], 12'h000};
					we  = 1'b1;
				end
				7'b0000011: begin
					addr = a + {{20{inst[31]}}, inst[31:20]};
					res  = model_dmem[addr[DMEM_AW+1:2]];
					we   = 1'b1;
				end
				7'b0100011: begin
					addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
					if (addr == `RV_LED_ADDR) begin
						model_leds = b[3:0];
					end else begin
						model_dmem[addr[DMEM_AW+1:2]] = b;
					end
				end
				7'b1100011: begin
					if ((inst[12] == 1'b0) == (a == b)) begin	// BEQ taken on equal, BNE on differ
						next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
							inst[11:8], 1'b0};
					end
				end
				7'b1101111: begin
					res     = pc + 32'd4;
					we      = 1'b1;
					next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
						inst[30:21], 1'b0};
				end
				default: ;
			endcase
			if (rd == '0) begin
				we = 1'b0;
			end
			if (we) begin
				model_regs[rd] = res;
			end
			exp_q.push_back('{valid: 1'b1, pc: pc, data: res, rd: rd, we: we});
			led_q.push_back(model_leds);
			done = (next_pc == pc);	// JAL to itself closes every program
			pc   = next_pc;
		end
	endfunction

	task automatic load_program();
		for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
			@(posedge clk);
			#1;
			load_we   = 1'b1;
			load_addr = i;
			load_data = prog[i];
		end
		@(posedge clk);
		#1;
		load_we = 1'b0;
	endtask

	task automatic feed_expected();
		while (exp_q.size() > 0) begin
			@(posedge clk);
			#1;
			exp_rec  = exp_q.pop_front();
			exp_leds = led_q.pop_front();
		end
		@(posedge clk);
		#1;
		exp_rec = '0;
	endtask

	function automatic string test_name(input int mode);
		case (mode)
			0: return "alu";
			1: return "x0";
			2: return "load_store";
			3: return "branch_jal";
			4: return "leds";
			default: return "mixed";
		endcase
	endfunction

	task automatic run_test(input int mode);
		int err_before;
		int n_rec;
		@(posedge clk);
		#1;
		load_en    = 1'b1;
		err_before = errors;
		build_program(mode);
		load_program();
		run_reference();
		n_rec = exp_q.size();
		feed_expected();
		load_en = 1'b0;	// Program starts from PC zero
		while (pending != 0) begin
			@(posedge clk);
		end
		tests_run++;
		$display("Test %0d %s: %0d retires expected, %0d errors", mode, test_name(mode),
			n_rec, errors - err_before);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with %0d retires still expected", cycles, pending);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h2f6c_bc2c));
		load_en    = 1'b1;
		load_we    = 1'b0;
		load_addr  = '0;
		load_data  = '0;
		exp_rec    = '0;
		exp_leds   = '0;
		model_leds = '0;
		tests_run  = 0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
			model_dmem[i] = '0;
		end
		@(posedge rst_n);
		for (int m = 0; m < N_TESTS; m++) begin
			run_test(m);
		end
		$display("Done: %0d tests, %0d retires checked, %0d errors", tests_run, checks, errors);
		if (errors == 0 && tests_run == N_TESTS) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== rv_core_top.f ====
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_memory.sv
rv_core_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_core_top.f --top-module tb_rv_core

out=$(./obj_dir/Vtb_rv_core)
echo "$out"

# The run counts as passed only when the pass line is printed
echo "$out" | grep -qx "sim passed"
